// ==== core_data_demux.f ====
hw/demux_bus_pkg.sv
hw/demux_map_pkg.sv
hw/addr_remap.sv
hw/dest_decode.sv
hw/periph_txn_ctrl.sv
hw/resp_select.sv
hw/core_data_demux.sv
testbench/demux_checker.sv
testbench/tb_core_data_demux.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the core_data_demux testbench with Verilator and run it.
# Passes only if the simulation prints the pass message.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
  -f core_data_demux.f --top-module tb_core_data_demux -Mdir obj_dir &&
./obj_dir/Vtb_core_data_demux | tee /dev/stderr | grep -qx 'PASS: all tests' ||
{ echo 'simulation did not pass' >&2; exit 1; }

// ==== testbench/tb_core_data_demux.sv ====
/*
 * Testbench for the core data demux.
 * Three target models grant after a random delay and answer with data derived
 * from the address. A table of core requests is applied one row at a time.
 */

`default_nettype none

module tb_core_data_demux
  import demux_bus_pkg::*;
();

  localparam int         NUM_ROWS     = 11;
  localparam int         RESET_CYCLES = 16;
  localparam int         MAX_CYCLES   = NUM_ROWS * 20 + RESET_CYCLES;
  localparam logic [1:0] T_SH         = 2'd0;
  localparam logic [1:0] T_EXT        = 2'd1;
  localparam logic [1:0] T_PE         = 2'd2;

  typedef struct packed {
    addr_t      addr;
    logic       wen;
    data_t      wdata;
    logic [1:0] tgt;
    addr_t      tgt_addr;
    logic       l2;
  } row_t;

  logic       clk = 1'b0;
  logic       rst_ni;
  logic [3:0] base_addr_i;
  logic [5:0] cluster_id_i;
  logic       data_req_i;
  addr_t      data_add_i;
  logic       data_wen_i;
  data_t      data_wdata_i;
  be_t        data_be_i;
  logic       data_gnt_o;
  logic       data_r_valid_o;
  logic       data_r_opc_o;
  data_t      data_r_rdata_o;
  logic       data_req_sh_o;
  logic       data_wen_sh_o;
  logic       data_gnt_sh_i;
  addr_t      data_add_sh_o;
  data_t      data_wdata_sh_o;
  be_t        data_be_sh_o;
  logic       data_req_ext_o;
  logic       data_wen_ext_o;
  logic       data_gnt_ext_i;
  addr_t      data_add_ext_o;
  data_t      data_wdata_ext_o;
  be_t        data_be_ext_o;
  logic       data_req_pe_o;
  logic       data_wen_pe_o;
  logic       data_gnt_pe_i;
  addr_t      data_add_pe_o;
  data_t      data_wdata_pe_o;
  be_t        data_be_pe_o;
  logic       perf_l2_ld_o;
  logic       perf_l2_st_o;
  logic       perf_l2_ld_cyc_o;
  logic       perf_l2_st_cyc_o;

  // Target model outputs
  logic        data_r_valid_sh_i  = 1'b0;
  data_t       data_r_rdata_sh_i  = '0;
  logic        data_r_valid_ext_i = 1'b0;
  data_t       data_r_rdata_ext_i = '0;
  logic        data_r_opc_ext_i   = 1'b0;
  logic        data_r_valid_pe_i  = 1'b0;
  data_t       data_r_rdata_pe_i  = '0;
  logic        data_r_opc_pe_i    = 1'b0;
  logic        gnt_ready          = 1'b0;
  logic [31:0] rng                = 32'h90b13d67;
  int          gnt_cnt            = 0;
  int          rsp_cnt            = 0;
  logic [1:0]  rsp_tgt            = T_SH;
  addr_t       rsp_addr           = '0;

  row_t table_q [NUM_ROWS];
  int   errors      = 0;
  int   row_errors  = 0;
  int   failed_rows = 0;
  int   cycle_cnt   = 0;

  core_data_demux i_core_data_demux (.*);

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Only one target is ever requested, so the models share one ready flag
  assign data_gnt_sh_i  = data_req_sh_o & gnt_ready;
  assign data_gnt_ext_i = data_req_ext_o & gnt_ready;
  assign data_gnt_pe_i  = data_req_pe_o & gnt_ready;

  always @(posedge clk) begin
    if (rsp_cnt != 0) begin
      rsp_cnt = rsp_cnt - 1;
    end
    if (data_gnt_sh_i || data_gnt_ext_i || data_gnt_pe_i) begin
      if (data_gnt_sh_i) begin
        rsp_tgt  = T_SH;
        rsp_addr = data_add_sh_o;
      end else if (data_gnt_ext_i) begin
        rsp_tgt  = T_EXT;
        rsp_addr = data_add_ext_o;
      end else begin
        rsp_tgt  = T_PE;
        rsp_addr = data_add_pe_o;
      end
      // PE answers 1 to 3 cycles after its grant, the others after one
      rng     = xorshift32(rng);
      rsp_cnt = (rsp_tgt == T_PE) ? 1 + int'(rng[7:0] % 8'd3) : 1;
      rng     = xorshift32(rng);
      gnt_cnt = int'(rng[1:0]);
    end else if ((data_req_sh_o || data_req_ext_o || data_req_pe_o) && gnt_cnt != 0) begin
      gnt_cnt = gnt_cnt - 1;
    end
  end

  always @(negedge clk) begin
    gnt_ready          <= (gnt_cnt == 0);
    data_r_valid_sh_i  <= (rsp_cnt == 1) && (rsp_tgt == T_SH);
    data_r_valid_ext_i <= (rsp_cnt == 1) && (rsp_tgt == T_EXT);
    data_r_valid_pe_i  <= (rsp_cnt == 1) && (rsp_tgt == T_PE);
    data_r_rdata_sh_i  <= rsp_addr ^ 32'hA5A5_0000;
    data_r_rdata_ext_i <= rsp_addr ^ 32'h5A5A_0000;
    data_r_opc_ext_i   <= rsp_addr[2];
    data_r_rdata_pe_i  <= rsp_addr ^ 32'h0F0F_0000;
    data_r_opc_pe_i    <= rsp_addr[2];
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic fill_table();
    // Core address, wen, wdata, target, address at the target, L2 traffic
    table_q[0]  = '{32'hC0C0_1000, 1'b1, 32'h0000_0000, T_SH, 32'h10C0_1000, 1'b0};
    table_q[1]  = '{32'hC0D0_0044, 1'b0, 32'h1234_5678, T_SH, 32'h10D0_0044, 1'b0};
    table_q[2]  = '{32'h0000_0100, 1'b1, 32'h0000_0000, T_SH, 32'h0000_0100, 1'b0};
    table_q[3]  = '{32'h0010_0208, 1'b0, 32'hCAFE_0003, T_SH, 32'h0010_0208, 1'b0};
    table_q[4]  = '{32'hC0E0_4004, 1'b1, 32'h0000_0000, T_EXT, 32'h10E0_4004, 1'b1};
    table_q[5]  = '{32'hC0E0_4008, 1'b0, 32'h0BAD_F00D, T_EXT, 32'h10E0_4008, 1'b1};
    table_q[6]  = '{32'h0020_4000, 1'b1, 32'h0000_0000, T_EXT, 32'h0020_4000, 1'b1};
    table_q[7]  = '{32'hC0E0_8004, 1'b1, 32'h0000_0000, T_PE, 32'h10E0_8004, 1'b1};
    table_q[8]  = '{32'h2000_0004, 1'b0, 32'h5555_AAAA, T_PE, 32'h2000_0004, 1'b1};
    table_q[9]  = '{32'h1000_0010, 1'b1, 32'h0000_0000, T_PE, 32'hC000_0010, 1'b1};
    table_q[10] = '{32'h7300_0000, 1'b1, 32'h0000_0000, T_PE, 32'h7300_0000, 1'b1};
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("** Error: %s is %h, expected %h", name, got, exp);
    errors++;
    row_errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("Error: %s", msg);
    errors++;
    row_errors++;
  endtask

  task automatic run_row(input int idx);
    row_t       r;
    logic [2:0] req_vec;
    logic [2:0] exp_vec;
    logic [1:0] exp_cyc;
    addr_t      port_add;
    data_t      port_wdata;
    logic       port_wen;
    be_t        port_be;
    be_t        exp_be;
    data_t      exp_rdata;
    logic       exp_opc;
    logic       exp_gnt;
    logic       granted;
    logic       seen_req;
    logic       pe_resp_seen;
    int         lat;
    r            = table_q[idx];
    row_errors   = 0;
    exp_vec      = 3'b001 << r.tgt;
    exp_cyc      = {r.l2 & r.wen, r.l2 & ~r.wen};
    exp_be       = ~be_t'(idx);
    granted      = 1'b0;
    seen_req     = 1'b0;
    pe_resp_seen = 1'b0;
    @(negedge clk);
    data_req_i   = 1'b1;
    data_add_i   = r.addr;
    data_wen_i   = r.wen;
    data_wdata_i = r.wdata;
    data_be_i    = exp_be;
    while (!granted) begin
      @(posedge clk);
      req_vec    = {data_req_pe_o, data_req_ext_o, data_req_sh_o};
      port_add   = (r.tgt == T_SH) ? data_add_sh_o :
                   (r.tgt == T_EXT) ? data_add_ext_o : data_add_pe_o;
      port_wdata = (r.tgt == T_SH) ? data_wdata_sh_o :
                   (r.tgt == T_EXT) ? data_wdata_ext_o : data_wdata_pe_o;
      port_wen   = (r.tgt == T_SH) ? data_wen_sh_o :
                   (r.tgt == T_EXT) ? data_wen_ext_o : data_wen_pe_o;
      port_be    = (r.tgt == T_SH) ? data_be_sh_o :
                   (r.tgt == T_EXT) ? data_be_ext_o : data_be_pe_o;
      // SH and EXT pass the target grant through, PE grants the cycle after its response
      exp_gnt    = (r.tgt == T_PE) ? pe_resp_seen : gnt_ready;
      if ((req_vec & ~exp_vec) != 3'b000) begin
        report_mismatch("target requests", 32'(req_vec), 32'(exp_vec));
      end
      if ((req_vec & exp_vec) != 3'b000) begin
        seen_req = 1'b1;
        if (port_add !== r.tgt_addr) begin
          report_mismatch("target address", port_add, r.tgt_addr);
        end
        if (port_wdata !== r.wdata) begin
          report_mismatch("target wdata", port_wdata, r.wdata);
        end
        if (port_wen !== r.wen) begin
          report_mismatch("target wen", 32'(port_wen), 32'(r.wen));
        end
        if (port_be !== exp_be) begin
          report_mismatch("target be", 32'(port_be), 32'(exp_be));
        end
      end
      if (data_gnt_o !== exp_gnt) begin
        report_mismatch("data_gnt_o", 32'(data_gnt_o), 32'(exp_gnt));
      end
      if ({perf_l2_ld_cyc_o, perf_l2_st_cyc_o} !== exp_cyc) begin
        report_mismatch("perf_l2_ld_cyc_o/st_cyc_o",
                        32'({perf_l2_ld_cyc_o, perf_l2_st_cyc_o}), 32'(exp_cyc));
      end
      if ({perf_l2_ld_o, perf_l2_st_o} !== (exp_cyc & {2{exp_gnt}})) begin
        report_mismatch("perf_l2_ld_o/st_o", 32'({perf_l2_ld_o, perf_l2_st_o}),
                        32'(exp_cyc & {2{exp_gnt}}));
      end
      if (data_gnt_o) begin
        granted = 1'b1;
      end
      if (data_r_valid_pe_i) begin
        pe_resp_seen = 1'b1;
      end
    end
    if (!seen_req) begin
      report_failure("the expected target never saw the request");
    end
    @(negedge clk);
    data_req_i = 1'b0;
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (!data_r_valid_o);
    if (lat != 1) begin
      report_failure($sformatf("response came %0d cycles after the grant, not 1", lat));
    end
    case (r.tgt)
      T_SH: exp_rdata = r.tgt_addr ^ 32'hA5A5_0000;
      T_EXT: exp_rdata = r.tgt_addr ^ 32'h5A5A_0000;
      default: exp_rdata = r.tgt_addr ^ 32'h0F0F_0000;
    endcase
    exp_opc = (r.tgt == T_SH) ? 1'b0 : r.tgt_addr[2];
    if (data_r_rdata_o !== exp_rdata) begin
      report_mismatch("data_r_rdata_o", data_r_rdata_o, exp_rdata);
    end
    if (data_r_opc_o !== exp_opc) begin
      report_mismatch("data_r_opc_o", 32'(data_r_opc_o), 32'(exp_opc));
    end
    if (row_errors != 0) begin
      failed_rows++;
    end
    $display("test %0d addr %h target %0d: %s", idx, r.addr, r.tgt,
             (row_errors == 0) ? "passed" : "failed");
  endtask

  initial begin
    rst_ni       = 1'b0;
    base_addr_i  = 4'hC;
    cluster_id_i = 6'd3;
    data_req_i   = 1'b0;
    data_add_i   = '0;
    data_wen_i   = 1'b0;
    data_wdata_i = '0;
    data_be_i    = '1;
    fill_table();
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      if ({data_req_sh_o, data_req_ext_o, data_req_pe_o} !== 3'b000) begin
        report_mismatch("target requests in reset",
                        32'({data_req_sh_o, data_req_ext_o, data_req_pe_o}), 32'h0);
      end
      if (data_gnt_o !== 1'b0) begin
        report_mismatch("data_gnt_o in reset", 32'(data_gnt_o), 32'h0);
      end
      if (data_r_valid_o !== 1'b0) begin
        report_mismatch("data_r_valid_o in reset", 32'(data_r_valid_o), 32'h0);
      end
    end
    @(negedge clk);
    rst_ni = 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    $display("%0d tests run, %0d failed, %0d errors", NUM_ROWS, failed_rows, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/demux_checker.sv ====
/*
 * Protocol assertions for the core data demux, bound into core_data_demux.
 * Covers target request exclusivity, core grant and PE response timing.
 */

`default_nettype none

module demux_checker (
  input logic clk,
  input logic rst_ni,
  input logic data_req_i,
  input logic data_gnt_i,
  input logic data_r_valid_i,
  input logic req_sh_i,
  input logic req_ext_i,
  input logic req_pe_i,
  input logic pe_core_gnt_i
);

  // At most one target sees the request
  assert property (@(posedge clk) disable iff (!rst_ni)
    $onehot0({req_sh_i, req_ext_i, req_pe_i}))
    else $error("more than one target request high");

  // The PE controller grants only while the core still holds its request
  assert property (@(posedge clk) disable iff (!rst_ni)
    (data_gnt_i || pe_core_gnt_i) |-> data_req_i)
    else $error("core grant without a core request");

  // Deferred PE grant, response one cycle later
  assert property (@(posedge clk) disable iff (!rst_ni) pe_core_gnt_i |=> data_r_valid_i)
    else $error("PE grant not followed by a core response");

endmodule

bind core_data_demux demux_checker i_demux_checker (
  .clk            (clk),
  .rst_ni         (rst_ni),
  .data_req_i     (data_req_i),
  .data_gnt_i     (data_gnt_o),
  .data_r_valid_i (data_r_valid_o),
  .req_sh_i       (data_req_sh_o),
  .req_ext_i      (data_req_ext_o),
  .req_pe_i       (data_req_pe_o),
  .pe_core_gnt_i  (pe_core_gnt)
);

`default_nettype wire

// ==== hw/core_data_demux.sv ====
/*
 * Core-side data demux of a cluster processor.
 * Steers each core load/store to the TCDM, the demux peripherals or the
 * peripheral interconnect, and returns the grant and response of that target.
 */

`default_nettype none

module core_data_demux
  import demux_bus_pkg::*;
  import demux_map_pkg::*;
#(
  parameter bit    REMAP_ADDRESS      = 1'b1,
  parameter bit    CLUSTER_ALIAS      = 1'b1,
  parameter page_t CLUSTER_ALIAS_BASE = 12'h000
) (
  input  logic       clk,
  input  logic       rst_ni,
  input  logic [3:0] base_addr_i,
  input  logic [5:0] cluster_id_i,

  // Core side
  input  logic       data_req_i,
  input  addr_t      data_add_i,
  input  logic       data_wen_i,
  input  data_t      data_wdata_i,
  input  be_t        data_be_i,
  output logic       data_gnt_o,
  output logic       data_r_valid_o,
  output data_t      data_r_rdata_o,
  output logic       data_r_opc_o,

  // Shared TCDM
  output logic       data_req_sh_o,
  output addr_t      data_add_sh_o,
  output logic       data_wen_sh_o,
  output data_t      data_wdata_sh_o,
  output be_t        data_be_sh_o,
  input  logic       data_gnt_sh_i,
  input  logic       data_r_valid_sh_i,
  input  data_t      data_r_rdata_sh_i,

  // Demux peripherals
  output logic       data_req_ext_o,
  output addr_t      data_add_ext_o,
  output logic       data_wen_ext_o,
  output data_t      data_wdata_ext_o,
  output be_t        data_be_ext_o,
  input  logic       data_gnt_ext_i,
  input  logic       data_r_valid_ext_i,
  input  data_t      data_r_rdata_ext_i,
  input  logic       data_r_opc_ext_i,

  // Peripheral interconnect
  output logic       data_req_pe_o,
  output addr_t      data_add_pe_o,
  output logic       data_wen_pe_o,
  output data_t      data_wdata_pe_o,
  output be_t        data_be_pe_o,
  input  logic       data_gnt_pe_i,
  input  logic       data_r_valid_pe_i,
  input  data_t      data_r_rdata_pe_i,
  input  logic       data_r_opc_pe_i,

  // L2 performance events
  output logic       perf_l2_ld_o,
  output logic       perf_l2_st_o,
  output logic       perf_l2_ld_cyc_o,
  output logic       perf_l2_st_cyc_o
);

  addr_t addr_int;
  dest_e dest;
  logic  pe_req;
  logic  pe_core_gnt;
  logic  pe_r_valid;
  data_t pe_r_rdata;
  logic  pe_r_opc;
  logic  l2_req;

  addr_remap #(
    .REMAP_ADDRESS (REMAP_ADDRESS)
  ) i_addr_remap (
    .data_add_i  (data_add_i),
    .base_addr_i (base_addr_i),
    .addr_int_o  (addr_int)
  );

  dest_decode #(
    .CLUSTER_ALIAS      (CLUSTER_ALIAS),
    .CLUSTER_ALIAS_BASE (CLUSTER_ALIAS_BASE)
  ) i_dest_decode (
    .addr_int_i   (addr_int),
    .cluster_id_i (cluster_id_i),
    .dest_o       (dest)
  );

  // Payload fans out to all targets, only the request is steered
  assign data_add_sh_o    = addr_int;
  assign data_wen_sh_o    = data_wen_i;
  assign data_wdata_sh_o  = data_wdata_i;
  assign data_be_sh_o     = data_be_i;
  assign data_add_ext_o   = addr_int;
  assign data_wen_ext_o   = data_wen_i;
  assign data_wdata_ext_o = data_wdata_i;
  assign data_be_ext_o    = data_be_i;
  assign data_add_pe_o    = addr_int;
  assign data_wen_pe_o    = data_wen_i;
  assign data_wdata_pe_o  = data_wdata_i;
  assign data_be_pe_o     = data_be_i;

  always_comb begin
    data_req_sh_o  = 1'b0;
    data_req_ext_o = 1'b0;
    pe_req         = 1'b0;
    data_gnt_o     = 1'b0;
    if (data_req_i) begin
      case (dest)
        SH: begin
          data_req_sh_o = 1'b1;
          data_gnt_o    = data_gnt_sh_i;
        end
        EXT: begin
          data_req_ext_o = 1'b1;
          data_gnt_o     = data_gnt_ext_i;
        end
        default: begin
          // PE grant is deferred until the peripheral has answered
          pe_req     = 1'b1;
          data_gnt_o = pe_core_gnt;
        end
      endcase
    end
  end

  periph_txn_ctrl i_periph_txn_ctrl (
    .clk               (clk),
    .rst_ni            (rst_ni),
    .req_i             (pe_req),
    .data_req_pe_o     (data_req_pe_o),
    .data_gnt_pe_i     (data_gnt_pe_i),
    .data_r_valid_pe_i (data_r_valid_pe_i),
    .data_r_rdata_pe_i (data_r_rdata_pe_i),
    .data_r_opc_pe_i   (data_r_opc_pe_i),
    .core_gnt_o        (pe_core_gnt),
    .pe_r_valid_o      (pe_r_valid),
    .pe_r_rdata_o      (pe_r_rdata),
    .pe_r_opc_o        (pe_r_opc)
  );

  resp_select i_resp_select (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .data_req_i     (data_req_i),
    .dest_i         (dest),
    .sh_r_valid_i   (data_r_valid_sh_i),
    .sh_r_rdata_i   (data_r_rdata_sh_i),
    .pe_r_valid_i   (pe_r_valid),
    .pe_r_rdata_i   (pe_r_rdata),
    .pe_r_opc_i     (pe_r_opc),
    .ext_r_valid_i  (data_r_valid_ext_i),
    .ext_r_rdata_i  (data_r_rdata_ext_i),
    .ext_r_opc_i    (data_r_opc_ext_i),
    .data_r_valid_o (data_r_valid_o),
    .data_r_rdata_o (data_r_rdata_o),
    .data_r_opc_o   (data_r_opc_o)
  );

  // Anything leaving the TCDM counts as L2 traffic, wen high means load
  assign l2_req           = data_req_i & (dest != SH);
  assign perf_l2_ld_cyc_o = l2_req & data_wen_i;
  assign perf_l2_st_cyc_o = l2_req & ~data_wen_i;
  assign perf_l2_ld_o     = perf_l2_ld_cyc_o & data_gnt_o;
  assign perf_l2_st_o     = perf_l2_st_cyc_o & data_gnt_o;

endmodule

`default_nettype wire

// ==== hw/resp_select.sv ====
/*
 * Response path back to the core.
 * Remembers where the last request went and forwards that target's response.
 */

`default_nettype none

module resp_select
  import demux_bus_pkg::*;
  import demux_map_pkg::*;
(
  input  logic  clk,
  input  logic  rst_ni,
  input  logic  data_req_i,
  input  dest_e dest_i,
  input  logic  sh_r_valid_i,
  input  data_t sh_r_rdata_i,
  input  logic  pe_r_valid_i,
  input  data_t pe_r_rdata_i,
  input  logic  pe_r_opc_i,
  input  logic  ext_r_valid_i,
  input  data_t ext_r_rdata_i,
  input  logic  ext_r_opc_i,
  output logic  data_r_valid_o,
  output data_t data_r_rdata_o,
  output logic  data_r_opc_o
);

  dest_e resp_dest_q;

  // Updated on every requesting cycle, so a held request keeps it stable
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_dest_q <= SH;
    end else if (data_req_i) begin
      resp_dest_q <= dest_i;
    end
  end

  always_comb begin
    case (resp_dest_q)
      SH: begin
        data_r_valid_o = sh_r_valid_i;
        data_r_rdata_o = sh_r_rdata_i;
        // TCDM never reports errors
        data_r_opc_o   = 1'b0;
      end
      PE: begin
        data_r_valid_o = pe_r_valid_i;
        data_r_rdata_o = pe_r_rdata_i;
        data_r_opc_o   = pe_r_opc_i;
      end
      EXT: begin
        data_r_valid_o = ext_r_valid_i;
        data_r_rdata_o = ext_r_rdata_i;
        data_r_opc_o   = ext_r_opc_i;
      end
      default: begin
        data_r_valid_o = 1'b0;
        data_r_rdata_o = '0;
        data_r_opc_o   = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/periph_txn_ctrl.sv ====
/*
 * Transaction control toward the peripheral interconnect.
 * The core is granted only after the peripheral has responded, and the
 * response reaches the core through two registers, one cycle after that grant.
 */

`default_nettype none

module periph_txn_ctrl
  import demux_bus_pkg::*;
(
  input  logic  clk,
  input  logic  rst_ni,
  input  logic  req_i,
  output logic  data_req_pe_o,
  input  logic  data_gnt_pe_i,
  input  logic  data_r_valid_pe_i,
  input  data_t data_r_rdata_pe_i,
  input  logic  data_r_opc_pe_i,
  output logic  core_gnt_o,
  output logic  pe_r_valid_o,
  output data_t pe_r_rdata_o,
  output logic  pe_r_opc_o
);

  typedef enum logic [1:0] {
    IDLE,
    PENDING,
    GRANTED
  } state_e;

  state_e state_q;
  state_e state_d;

  logic  r_valid_q0;
  data_t r_rdata_q0;
  logic  r_opc_q0;

  always_comb begin
    state_d       = state_q;
    data_req_pe_o = 1'b0;
    core_gnt_o    = 1'b0;
    case (state_q)
      IDLE: begin
        if (req_i) begin
          data_req_pe_o = 1'b1;
          if (data_gnt_pe_i) begin
            state_d = PENDING;
          end
        end
      end
      PENDING: begin
        // Response latency of the peripheral is unbounded
        if (data_r_valid_pe_i) begin
          state_d = GRANTED;
        end
      end
      GRANTED: begin
        core_gnt_o = 1'b1;
        state_d    = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Two response stages, valid under reset and payload loaded on valid beats
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q0   <= 1'b0;
      pe_r_valid_o <= 1'b0;
    end else begin
      r_valid_q0   <= data_r_valid_pe_i;
      pe_r_valid_o <= r_valid_q0;
    end
  end

  always_ff @(posedge clk) begin
    if (data_r_valid_pe_i) begin
      r_rdata_q0 <= data_r_rdata_pe_i;
      r_opc_q0   <= data_r_opc_pe_i;
    end
    if (r_valid_q0) begin
      pe_r_rdata_o <= r_rdata_q0;
      pe_r_opc_o   <= r_opc_q0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/dest_decode.sv ====
/*
 * Address decoder selecting SH, EXT or PE for a remapped core address.
 * Own pages come from cluster_id_i, alias pages from CLUSTER_ALIAS_BASE.
 * Purely combinational.
 */

`default_nettype none

module dest_decode
  import demux_bus_pkg::*;
  import demux_map_pkg::*;
#(
  parameter bit    CLUSTER_ALIAS      = 1'b1,
  parameter page_t CLUSTER_ALIAS_BASE = 12'h000
) (
  input  addr_t      addr_int_i,
  input  logic [5:0] cluster_id_i,
  output dest_e      dest_o
);

  page_t page;
  page_t own_base;
  page_t tcdm_rw_page;
  page_t tcdm_ts_page;
  page_t dem_per_page;
  page_t alias_rw_page;
  page_t alias_ts_page;
  page_t alias_dem_page;
  logic  hit_tcdm;
  logic  hit_dem_per;
  logic  in_demux_win;

  assign page = addr_int_i[PAGE_MSB:PAGE_LSB];

  // Four pages per cluster
  assign own_base     = CLUSTER_PAGE_BASE + {4'b0000, cluster_id_i, 2'b00};
  assign tcdm_rw_page = own_base + TCDM_RW_OFS;
  assign tcdm_ts_page = own_base + TCDM_TS_OFS;
  assign dem_per_page = own_base + DEM_PER_OFS;

  assign alias_rw_page  = CLUSTER_ALIAS_BASE + TCDM_RW_OFS;
  assign alias_ts_page  = CLUSTER_ALIAS_BASE + TCDM_TS_OFS;
  assign alias_dem_page = CLUSTER_ALIAS_BASE + DEM_PER_OFS;

  assign hit_tcdm = (page == tcdm_rw_page) || (page == tcdm_ts_page) ||
                    (CLUSTER_ALIAS && ((page == alias_rw_page) || (page == alias_ts_page)));

  assign hit_dem_per = (page == dem_per_page) ||
                       (CLUSTER_ALIAS && (page == alias_dem_page));

  assign in_demux_win = (addr_int_i[DEMUX_PER_MSB:DEMUX_PER_LSB] == DEMUX_PER_VAL);

  always_comb begin
    dest_o = PE;
    if (hit_tcdm) begin
      dest_o = SH;
    end else if (hit_dem_per && in_demux_win) begin
      dest_o = EXT;
    end
  end

endmodule

`default_nettype wire

// ==== hw/addr_remap.sv ====
/*
 * Optional swap of the address top nibble between base_addr_i and nibble 1.
 * Lets a cluster reach its own resources through the base_addr_i alias.
 */

`default_nettype none

module addr_remap
  import demux_bus_pkg::*;
  import demux_map_pkg::*;
#(
  parameter bit REMAP_ADDRESS = 1'b1
) (
  input  addr_t      data_add_i,
  input  logic [3:0] base_addr_i,
  output addr_t      addr_int_o
);

  localparam int NIB_LSB = ADDR_WIDTH - 4;

  logic [3:0] top_nibble;

  assign top_nibble = data_add_i[ADDR_WIDTH-1:NIB_LSB];

  if (REMAP_ADDRESS) begin : gen_remap
    always_comb begin
      addr_int_o = data_add_i;
      // base_addr_i region maps onto nibble 1 and vice versa
      if (top_nibble == base_addr_i) begin
        addr_int_o[ADDR_WIDTH-1:NIB_LSB] = REMAP_NIBBLE;
      end else if (top_nibble == REMAP_NIBBLE) begin
        addr_int_o[ADDR_WIDTH-1:NIB_LSB] = base_addr_i;
      end
    end
  end else begin : gen_no_remap
    assign addr_int_o = data_add_i;
  end

endmodule

`default_nettype wire

// ==== hw/demux_map_pkg.sv ====
/*
 * Cluster memory map and destination encoding for the data demux.
 * The decoder and response select import the page constants and dest_e.
 */

`default_nettype none

package demux_map_pkg;

  // Targets a core request can be steered to
  typedef enum logic [1:0] {
    SH  = 2'd0,
    PE  = 2'd1,
    EXT = 2'd2
  } dest_e;

  // Address bits 31:20 select a 1 MiB page
  parameter int PAGE_MSB = 31;
  parameter int PAGE_LSB = 20;

  typedef logic [PAGE_MSB-PAGE_LSB:0] page_t;

  // Cluster n owns four pages starting at base + 4*n
  parameter page_t CLUSTER_PAGE_BASE = 12'h100;
  parameter page_t TCDM_RW_OFS       = 12'd0;
  parameter page_t TCDM_TS_OFS       = 12'd1;
  parameter page_t DEM_PER_OFS       = 12'd2;

  // Demux peripheral window inside the DEM_PER page
  parameter int                                DEMUX_PER_MSB = 19;
  parameter int                                DEMUX_PER_LSB = 10;
  parameter logic [DEMUX_PER_MSB-DEMUX_PER_LSB:0] DEMUX_PER_VAL = 10'b0000010000;

  // Nibble swapped with base_addr_i by the remap
  parameter logic [3:0] REMAP_NIBBLE = 4'h1;

endpackage

`default_nettype wire

// ==== hw/demux_bus_pkg.sv ====
/*
 * Core load/store bus widths and word types.
 * Imported by every module that carries addresses, data or byte enables.
 */

`default_nettype none

package demux_bus_pkg;

  parameter int ADDR_WIDTH = 32;
  parameter int DATA_WIDTH = 32;
  parameter int BE_WIDTH   = DATA_WIDTH / 8;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [BE_WIDTH-1:0]   be_t;

endpackage

`default_nettype wire
